/* design/heapAllocator.sv */
/*
  Hands out array numbers for the engine. Released numbers go on a stack and
  are reused last in, first out before any new number is handed out.
  isAllocated and wasFreed describe queryArray in the same cycle.
*/
module heapAllocator (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             clear,           // Software reset
  input  logic                             allocate,
  input  logic                             free,
  input  logic [heapPkg::ADDRESS_BITS-1:0] releaseArray,
  input  logic [heapPkg::ADDRESS_BITS-1:0] queryArray,
  output logic [heapPkg::ADDRESS_BITS-1:0] allocatedArray,  // Next number to hand out
  output logic                             outOfMemory,
  output logic                             isAllocated,
  output logic                             wasFreed
);

  import heapPkg::*;

  logic [ARRAYS-1:0]       allocated;               // One flag per array
  logic [ADDRESS_BITS:0]   highWater;               // Numbers ever handed out
  logic [ADDRESS_BITS:0]   stackTop;                // Freed numbers on the stack
  logic [ADDRESS_BITS-1:0] freedStack [ARRAYS];
  logic                    reuse;                   // Stack has a number

  assign reuse = (stackTop != '0);

  assign allocatedArray = reuse ? freedStack[ADDRESS_BITS'(stackTop - 1'b1)]
                                : highWater[ADDRESS_BITS-1:0];
  assign outOfMemory = !reuse && (highWater == (ADDRESS_BITS + 1)'(ARRAYS));

  assign isAllocated = allocated[queryArray];
  assign wasFreed    = !allocated[queryArray] && ({1'b0, queryArray} < highWater);

  // --------------------
  // Flags and counters
  // --------------------
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      allocated <= '0;
      highWater <= '0;
      stackTop  <= '0;
    end else if (allocate && !outOfMemory) begin
      allocated[allocatedArray] <= 1'b1;
      if (reuse) begin
        stackTop <= stackTop - 1'b1;                // Pop the freed number
      end else begin
        highWater <= highWater + 1'b1;              // Fresh number
      end
    end else if (free) begin
      allocated[releaseArray] <= 1'b0;
      stackTop                <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (free) freedStack[ADDRESS_BITS'(stackTop)] <= releaseArray;
  end

  // Empty stack stays empty or takes one number
  stackNoUnderflow: assert property (@(posedge clock) disable iff (reset)
    (stackTop == '0) |=> (stackTop <= (ADDRESS_BITS + 1)'(1)));

endmodule

/* design/heapArrayEngine.sv */
/*
  Executes one queued command per clock against the element memory and
  pushes exactly one result word for it. Access is checked through the
  allocator's flags and the index against the array's size.
*/
module heapArrayEngine (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] commandWord,   // Head of command queue
  input  logic        commandEmpty,
  output logic        commandPop,
  output logic [31:0] resultWord,
  output logic        resultPush,
  input  logic        resultFull
);

  import heapPkg::*;

  localparam int SIZE_BITS = INDEX_BITS + 1;
  localparam logic [SIZE_BITS-1:0] FULL_SIZE = SIZE_BITS'(ARRAY_LENGTH);

  logic [DATA_BITS-1:0]    memory [ARRAYS][ARRAY_LENGTH];
  logic [SIZE_BITS-1:0]    sizes [ARRAYS];          // Elements in use per array

  heapCommand              command;
  heapResult               result;
  logic                    fire;                    // Execute on this edge
  logic [SIZE_BITS-1:0]    arraySize;
  logic                    inBounds;
  logic [INDEX_BITS-1:0]   elementIndex;            // Element touched by the command
  logic [DATA_BITS-1:0]    storedElement;
  logic [SIZE_BITS-1:0]    matchIndex;              // One based, zero when absent
  logic [SIZE_BITS-1:0]    lessCount;
  logic [SIZE_BITS-1:0]    greaterCount;

  heapErrorCode            error;
  heapErrorCode            accessError;
  heapErrorCode            readError;
  logic [DATA_BITS-1:0]    value;
  logic                    writeElement;
  logic [DATA_BITS-1:0]    writeData;
  logic                    writeSize;
  logic [ADDRESS_BITS-1:0] sizeArray;
  logic [SIZE_BITS-1:0]    newSize;
  logic                    clearRequest;
  logic                    allocRequest;
  logic                    releaseRequest;

  logic [ADDRESS_BITS-1:0] allocatedArray;
  logic                    outOfMemory;
  logic                    isAllocated;
  logic                    wasFreed;

  assign command    = commandWord;
  assign fire       = !commandEmpty && !resultFull;  // Stall on full results
  assign commandPop = fire;
  assign resultPush = fire;
  assign resultWord = result;

  heapAllocator allocator (
    .clock          (clock),
    .reset          (reset),
    .clear          (fire && clearRequest),
    .allocate       (fire && allocRequest),
    .free           (fire && releaseRequest),
    .releaseArray   (command.array),
    .queryArray     (command.array),
    .allocatedArray (allocatedArray),
    .outOfMemory    (outOfMemory),
    .isAllocated    (isAllocated),
    .wasFreed       (wasFreed)
  );

  // --------------------
  // Operands
  // --------------------
  assign arraySize = sizes[command.array];
  assign inBounds  = ({1'b0, command.index} < arraySize);

  always_comb begin
    elementIndex = command.index;
    if (command.opcode == opPush) elementIndex = arraySize[INDEX_BITS-1:0];          // Next slot
    if (command.opcode == opPop)  elementIndex = INDEX_BITS'(arraySize - 1'b1);       // Top slot
  end

  assign storedElement = memory[command.array][elementIndex];

  assign accessError = isAllocated ? errNone : (wasFreed ? errFreed : errNotAllocated);
  assign readError   = (accessError != errNone) ? accessError
                     : (inBounds ? errNone : errOutOfBounds);

  always_comb begin
    matchIndex   = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      if (SIZE_BITS'(i) < arraySize) begin                                          // Used part only
        if (memory[command.array][i] == command.data) matchIndex   = SIZE_BITS'(i + 1);
        if (memory[command.array][i] <  command.data) lessCount    = lessCount + 1'b1;
        if (memory[command.array][i] >  command.data) greaterCount = greaterCount + 1'b1;
      end
    end
  end

  // --------------------
  // Decode and execute
  // --------------------
  always_comb begin
    error          = errNone;
    value          = '0;
    writeElement   = 1'b0;
    writeData      = command.data;
    writeSize      = 1'b0;
    sizeArray      = command.array;
    newSize        = arraySize;
    clearRequest   = 1'b0;
    allocRequest   = 1'b0;
    releaseRequest = 1'b0;
    case (command.opcode)
      opReset: clearRequest = 1'b1;
      opAlloc: begin
        if (outOfMemory) error = errOutOfMemory;
        allocRequest = 1'b1;
        writeSize    = 1'b1;                        // New array starts empty
        sizeArray    = allocatedArray;
        newSize      = '0;
        value        = DATA_BITS'(allocatedArray);
      end
      opFree: begin
        error          = accessError;
        releaseRequest = 1'b1;
        value          = DATA_BITS'(command.array);
      end
      opWrite: begin
        error        = accessError;
        writeElement = 1'b1;
        writeSize    = !inBounds;                   // Grows the array
        newSize      = {1'b0, command.index} + 1'b1;
        value        = command.data;
      end
      opRead: begin
        error = readError;
        value = storedElement;
      end
      opSize: begin
        error = accessError;
        value = DATA_BITS'(arraySize);
      end
      opIndex: begin
        error = accessError;
        value = DATA_BITS'(matchIndex);
      end
      opLess: begin
        error = accessError;
        value = DATA_BITS'(lessCount);
      end
      opGreater: begin
        error = accessError;
        value = DATA_BITS'(greaterCount);
      end
      opPush: begin
        error = accessError;
        if (error == errNone && arraySize == FULL_SIZE) error = errFull;
        writeElement = 1'b1;
        writeSize    = 1'b1;
        newSize      = arraySize + 1'b1;
        value        = command.data;                // Pushed value echoed
      end
      opPop: begin
        error = accessError;
        if (error == errNone && arraySize == '0) error = errEmpty;
        writeSize = 1'b1;
        newSize   = arraySize - 1'b1;
        value     = storedElement;
      end
      opAdd, opSubtract, opOr, opXor, opAnd: begin
        error = readError;
        case (command.opcode)
          opAdd:      writeData = storedElement + command.data;  // Wraps at 12 bits
          opSubtract: writeData = storedElement - command.data;
          opOr:       writeData = storedElement | command.data;
          opXor:      writeData = storedElement ^ command.data;
          default:    writeData = storedElement & command.data;
        endcase
        writeElement = 1'b1;
        value        = writeData;                   // New value returned
      end
      default: error = errBadOpcode;
    endcase

    if (error != errNone) begin                     // A failed command changes nothing
      writeElement   = 1'b0;
      writeSize      = 1'b0;
      allocRequest   = 1'b0;
      releaseRequest = 1'b0;
    end

    result = '0;
    if (error != errNone) begin
      result.error.isError = 1'b1;
      result.error.code    = error;
    end else begin
      result.value.value = value;
    end
  end

  // --------------------
  // State update
  // --------------------
  always_ff @(posedge clock) begin
    if (fire && writeElement) memory[command.array][elementIndex] <= writeData;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sizes <= '{default: '0};
    end else if (fire && writeSize) begin
      sizes[sizeArray] <= newSize;
    end
  end

  for (genvar g = 0; g < ARRAYS; g++) begin : sizeChecks
    sizeWithinLength: assert property (@(posedge clock) disable iff (reset)
      sizes[g] <= FULL_SIZE);
  end

endmodule

/* design/heapArrays.sv */
/*
  Top level of the array heap. Commands written over Wishbone wait in one
  queue, the engine executes them in order and its results wait in a second
  queue until the host reads them back.
*/
module heapArrays #(
  parameter int COMMAND_DEPTH = 4,  // Commands waiting for the engine
  parameter int RESULT_DEPTH  = 4   // Results waiting for the host
) (
  input  logic                clock,
  input  logic                reset,
  input  heapPkg::wbRequest   busRequest,
  output heapPkg::wbResponse  busResponse
);

  logic        commandPush;   // Bus port into command queue
  logic [31:0] commandWord;
  logic        commandPop;    // Engine takes a command
  logic [31:0] commandHead;
  logic        commandFull;
  logic        commandEmpty;
  logic        resultPush;    // Engine gives a result
  logic [31:0] resultWord;
  logic        resultPop;     // Bus port takes a result
  logic [31:0] resultHead;
  logic        resultFull;
  logic        resultEmpty;

  heapBusPort busPort (
    .clock       (clock),
    .reset       (reset),
    .busRequest  (busRequest),
    .busResponse (busResponse),
    .commandPush (commandPush),
    .commandWord (commandWord),
    .commandFull (commandFull),
    .resultPop   (resultPop),
    .resultWord  (resultHead),
    .resultEmpty (resultEmpty)
  );

  heapFifo #(.DEPTH(COMMAND_DEPTH)) commandQueue (
    .clock     (clock),
    .reset     (reset),
    .push      (commandPush),
    .writeWord (commandWord),
    .pop       (commandPop),
    .readWord  (commandHead),
    .full      (commandFull),
    .empty     (commandEmpty)
  );

  heapFifo #(.DEPTH(RESULT_DEPTH)) resultQueue (
    .clock     (clock),
    .reset     (reset),
    .push      (resultPush),
    .writeWord (resultWord),
    .pop       (resultPop),
    .readWord  (resultHead),
    .full      (resultFull),
    .empty     (resultEmpty)
  );

  heapArrayEngine engine (
    .clock        (clock),
    .reset        (reset),
    .commandWord  (commandHead),
    .commandEmpty (commandEmpty),
    .commandPop   (commandPop),
    .resultWord   (resultWord),
    .resultPush   (resultPush),
    .resultFull   (resultFull)
  );

endmodule

/* design/heapBusPort.sv */
/*
  Wishbone classic slave of the heap. A write to address 0 queues a command,
  a read from address 0 pops a result. Address 1 is a dummy register. The ack
  is registered and is held back while the queue on the chosen side cannot move.
*/
module heapBusPort (
  input  logic                clock,
  input  logic                reset,
  input  heapPkg::wbRequest   busRequest,
  output heapPkg::wbResponse  busResponse,
  output logic                commandPush,
  output logic [31:0]         commandWord,
  input  logic                commandFull,
  output logic                resultPop,
  input  logic [31:0]         resultWord,
  input  logic                resultEmpty
);

  logic        ack;          // Registered acknowledge
  logic [31:0] readData;     // Word returned with the ack
  logic        heapSelect;   // Address 0
  logic        ready;        // Chosen queue can move
  logic        accept;       // Transfer completes on this edge

  assign heapSelect = (busRequest.adr == 1'b0);

  always_comb begin
    ready = 1'b1;                                   // Dummy register never waits
    if (heapSelect) begin
      ready = busRequest.we ? !commandFull : !resultEmpty;
    end
  end

  // Ack high means the host still shows the cycle just finished
  assign accept = busRequest.cyc && busRequest.stb && !ack && ready;

  assign commandPush = accept && busRequest.we && heapSelect;
  assign commandWord = busRequest.dat;
  assign resultPop   = accept && !busRequest.we && heapSelect;

  // --------------------
  // Response registers
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= accept;                                // Exactly one cycle
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      readData <= resultPop ? resultWord : '0;      // Dummy reads as zero
    end
  end

  assign busResponse.ack = ack;
  assign busResponse.dat = readData;

  // --------------------
  // Protocol checks
  // --------------------
  ackFollowsStrobe: assert property (@(posedge clock) disable iff (reset)
    ack |-> $past(busRequest.cyc && busRequest.stb));

  ackSingleCycle: assert property (@(posedge clock) disable iff (reset)
    ack |=> !ack);

endmodule

/* design/heapFifo.sv */
/*
  Synchronous queue of 32-bit words. The head word shows on readWord before it
  is popped. Push and pop may share an edge, and a push when full or a pop
  when empty is a caller error.
*/
module heapFifo #(
  parameter int DEPTH = 4  // Words held, at least 2
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        push,
  input  logic [31:0] writeWord,
  input  logic        pop,
  output logic [31:0] readWord,
  output logic        full,
  output logic        empty
);

  localparam int POINTER_BITS = $clog2(DEPTH);

  logic [31:0]             storage [DEPTH];
  logic [POINTER_BITS-1:0] readPointer;
  logic [POINTER_BITS-1:0] writePointer;
  logic [POINTER_BITS:0]   count;         // Words held

  function automatic logic [POINTER_BITS-1:0] advance(input logic [POINTER_BITS-1:0] pointer);
    return (pointer == POINTER_BITS'(DEPTH - 1)) ? '0 : pointer + 1'b1;  // Wrap at DEPTH
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      readPointer  <= '0;
      writePointer <= '0;
      count        <= '0;
    end else begin
      if (push) writePointer <= advance(writePointer);
      if (pop)  readPointer  <= advance(readPointer);
      count <= count + (POINTER_BITS + 1)'(push) - (POINTER_BITS + 1)'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) storage[writePointer] <= writeWord;
  end

  assign readWord = storage[readPointer];   // Head word
  assign full     = (count == (POINTER_BITS + 1)'(DEPTH));
  assign empty    = (count == '0);

  noPushWhenFull: assert property (@(posedge clock) disable iff (reset) full |-> !push);
  noPopWhenEmpty: assert property (@(posedge clock) disable iff (reset) empty |-> !pop);

endmodule

/* design/heapPkg.sv */
/*
  Shared constants and types of the array heap: geometry, opcodes, error
  codes, the command and result words and the Wishbone request and response.
  Import it wherever one of these names is used.
*/
package heapPkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int ADDRESS_BITS = 2;                // Bits in an array number
  localparam int INDEX_BITS   = 2;                // Bits in an element index
  localparam int DATA_BITS    = 12;               // Bits in an element
  localparam int ARRAYS       = 2 ** ADDRESS_BITS;
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;  // Elements per array

  // --------------------
  // Opcodes and errors
  // --------------------
  typedef enum logic [4:0] {
    opReset    = 5'd1,   // Forget all arrays
    opWrite    = 5'd2,   // Write element, grows size
    opRead     = 5'd3,
    opSize     = 5'd4,
    opIndex    = 5'd7,   // One based index of last match
    opLess     = 5'd8,   // Count below input
    opGreater  = 5'd9,   // Count above input
    opPush     = 5'd14,
    opPop      = 5'd15,
    opAlloc    = 5'd18,
    opFree     = 5'd19,
    opAdd      = 5'd20,  // Arithmetic ops return the new value
    opSubtract = 5'd22,
    opOr       = 5'd28,
    opXor      = 5'd29,
    opAnd      = 5'd30
  } heapOpcode;

  typedef enum logic [7:0] {
    errNone         = 8'd0,
    errNotAllocated = 8'd1,  // Never handed out
    errFreed        = 8'd2,  // Handed out, then released
    errOutOfBounds  = 8'd3,
    errFull         = 8'd4,  // Push onto a full array
    errEmpty        = 8'd5,  // Pop from an empty array
    errOutOfMemory  = 8'd6,
    errBadOpcode    = 8'd7
  } heapErrorCode;

  // --------------------
  // Command and result
  // --------------------
  typedef struct packed {
    logic [31-5-ADDRESS_BITS-INDEX_BITS-DATA_BITS:0] unused;  // Zero
    heapOpcode                                      opcode;
    logic [ADDRESS_BITS-1:0]                        array;
    logic [INDEX_BITS-1:0]                          index;
    logic [DATA_BITS-1:0]                           data;
  } heapCommand;

  typedef union packed {
    struct packed {
      logic                   isError;  // Low in this view
      logic [30-DATA_BITS:0]  zeros;
      logic [DATA_BITS-1:0]   value;    // Zero extended
    } value;
    struct packed {
      logic                   isError;  // High in this view
      logic [22:0]            zeros;
      heapErrorCode           code;
    } error;
  } heapResult;

  // --------------------
  // Wishbone classic
  // --------------------
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic        adr;  // 0 is the heap port, 1 is a dummy register
    logic [31:0] dat;
  } wbRequest;

  typedef struct packed {
    logic        ack;  // One cycle per transfer
    logic [31:0] dat;
  } wbResponse;

endpackage

/* heapArrays.f */
design/heapPkg.sv
design/heapFifo.sv
design/heapBusPort.sv
design/heapAllocator.sv
design/heapArrayEngine.sv
design/heapArrays.sv
tb/heapChecker.sv
tb/heapArraysTb.sv

/* run.sh */
#!/bin/sh
# Builds the heap testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module heapArraysTb \
  -f heapArrays.f \
  && obj_dir/VheapArraysTb | tee /dev/stderr | grep -qx "Test completed successfully" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* tb/heapArraysTb.sv */
/*
  Testbench of the array heap. Writes each test's commands over Wishbone as
  one burst, then reads the results back. heapChecker does the comparing.
*/
module heapArraysTb;

  import heapPkg::*;

  typedef struct packed {
    logic [7:0]  test;       // Test number
    logic [31:0] command;
    logic [31:0] expected;   // Result word
  } stimulusRow;

  localparam int BURST_LIMIT = 6;   // Commands written before reading

  logic        clock;
  logic        reset;
  wbRequest    busRequest;
  wbResponse   busResponse;
  logic        expectPush;
  logic [7:0]  expectTest;
  logic [31:0] expectWord;
  logic        expectLast;
  int          checkCount;
  int          errorCount;
  stimulusRow  stimulus [$];
  logic        tableReady;

  // Six commands fill both queues and stall the engine
  heapArrays #(.COMMAND_DEPTH(2), .RESULT_DEPTH(4)) UUT (
    .clock       (clock),
    .reset       (reset),
    .busRequest  (busRequest),
    .busResponse (busResponse)
  );

  heapChecker resultChecker (
    .clock       (clock),
    .reset       (reset),
    .busRequest  (busRequest),
    .busResponse (busResponse),
    .expectPush  (expectPush),
    .expectTest  (expectTest),
    .expectWord  (expectWord),
    .expectLast  (expectLast),
    .checkCount  (checkCount),
    .errorCount  (errorCount)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // --------------------
  // Word builders
  // --------------------
  function automatic logic [31:0] makeCommand(input heapOpcode op, input int array,
                                              input int index, input int data);
    heapCommand command;
    command        = '0;
    command.opcode = op;
    command.array  = ADDRESS_BITS'(array);
    command.index  = INDEX_BITS'(index);
    command.data   = DATA_BITS'(data);
    return command;
  endfunction

  function automatic logic [31:0] valueWord(input int value);
    return {20'b0, 12'(value)};              // Flag low, value zero extended
  endfunction

  function automatic logic [31:0] errorWord(input heapErrorCode code);
    return {1'b1, 23'b0, code};              // Flag high, code in low byte
  endfunction

  function automatic void addRow(input int test, input logic [31:0] command,
                                 input logic [31:0] expected);
    stimulusRow row;
    row.test     = 8'(test);
    row.command  = command;
    row.expected = expected;
    stimulus.push_back(row);
  endfunction

  function automatic void buildTable();
    // Allocation from a cleared heap
    addRow(1, makeCommand(opReset, 0, 0, 0), valueWord(0));
    addRow(1, makeCommand(opAlloc, 0, 0, 0), valueWord(0));
    addRow(1, makeCommand(opAlloc, 0, 0, 0), valueWord(1));
    addRow(1, makeCommand(opAlloc, 0, 0, 0), valueWord(2));
    addRow(1, makeCommand(opAlloc, 0, 0, 0), valueWord(3));
    addRow(1, makeCommand(opAlloc, 0, 0, 0), errorWord(errOutOfMemory));
    // Freed numbers come back last in, first out
    addRow(2, makeCommand(opFree, 2, 0, 0), valueWord(2));
    addRow(2, makeCommand(opFree, 1, 0, 0), valueWord(1));
    addRow(2, makeCommand(opAlloc, 0, 0, 0), valueWord(1));
    addRow(2, makeCommand(opAlloc, 0, 0, 0), valueWord(2));
    addRow(2, makeCommand(opFree, 3, 0, 0), valueWord(3));
    addRow(2, makeCommand(opRead, 3, 0, 0), errorWord(errFreed));
    // Write grows the size
    addRow(3, makeCommand(opReset, 0, 0, 0), valueWord(0));
    addRow(3, makeCommand(opRead, 0, 0, 0), errorWord(errNotAllocated));
    addRow(3, makeCommand(opAlloc, 0, 0, 0), valueWord(0));
    addRow(3, makeCommand(opWrite, 0, 2, 'h123), valueWord('h123));
    addRow(3, makeCommand(opSize, 0, 0, 0), valueWord(3));
    addRow(3, makeCommand(opRead, 0, 3, 0), errorWord(errOutOfBounds));
    // Stack fill
    addRow(4, makeCommand(opAlloc, 0, 0, 0), valueWord(1));
    addRow(4, makeCommand(opPush, 1, 0, 10), valueWord(10));
    addRow(4, makeCommand(opPush, 1, 0, 20), valueWord(20));
    addRow(4, makeCommand(opPush, 1, 0, 30), valueWord(30));
    addRow(4, makeCommand(opPush, 1, 0, 20), valueWord(20));
    addRow(4, makeCommand(opPush, 1, 0, 40), errorWord(errFull));
    // Searches over 10 20 30 20
    addRow(5, makeCommand(opIndex, 1, 0, 20), valueWord(4));
    addRow(5, makeCommand(opIndex, 1, 0, 5), valueWord(0));
    addRow(5, makeCommand(opLess, 1, 0, 25), valueWord(3));
    addRow(5, makeCommand(opGreater, 1, 0, 10), valueWord(3));
    addRow(5, makeCommand(opSize, 1, 0, 0), valueWord(4));
    addRow(5, makeCommand(opRead, 1, 2, 0), valueWord(30));
    // Stack drain
    addRow(6, makeCommand(opPop, 1, 0, 0), valueWord(20));
    addRow(6, makeCommand(opPop, 1, 0, 0), valueWord(30));
    addRow(6, makeCommand(opPop, 1, 0, 0), valueWord(20));
    addRow(6, makeCommand(opPop, 1, 0, 0), valueWord(10));
    addRow(6, makeCommand(opPop, 1, 0, 0), errorWord(errEmpty));
    addRow(6, makeCommand(opSize, 1, 0, 0), valueWord(0));
    // Arithmetic wraps at 12 bits
    addRow(7, makeCommand(opAlloc, 0, 0, 0), valueWord(2));
    addRow(7, makeCommand(opWrite, 2, 0, 'hFF0), valueWord('hFF0));
    addRow(7, makeCommand(opAdd, 2, 0, 'h020), valueWord('h010));
    addRow(7, makeCommand(opSubtract, 2, 0, 'h011), valueWord('hFFF));
    addRow(7, makeCommand(opRead, 2, 0, 0), valueWord('hFFF));
    addRow(7, makeCommand(opAnd, 2, 0, 'h5A5), valueWord('h5A5));
    addRow(8, makeCommand(opXor, 2, 0, 'h0FF), valueWord('h55A));
    addRow(8, makeCommand(opOr, 2, 0, 'h200), valueWord('h75A));
    addRow(8, makeCommand(opRead, 2, 0, 0), valueWord('h75A));
    addRow(8, makeCommand(opFree, 2, 0, 0), valueWord(2));
    addRow(8, makeCommand(opRead, 2, 0, 0), errorWord(errFreed));
    addRow(8, makeCommand(opRead, 3, 0, 0), errorWord(errNotAllocated));
  endfunction

  // --------------------
  // Bus driver
  // --------------------
  task automatic idleGap();
    repeat ($urandom % 4) @(negedge clock);  // 0 to 3 idle cycles
  endtask

  task automatic busWrite(input logic [31:0] word);
    @(negedge clock);
    busRequest = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: 1'b0, dat: word};
    do begin
      @(negedge clock);
    end while (!busResponse.ack);            // Held off while the queue is full
    busRequest = '0;
    idleGap();
  endtask

  task automatic busRead(input logic [7:0] test, input logic [31:0] expected,
                         input logic last);
    @(negedge clock);
    busRequest = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: 1'b0, dat: 32'b0};
    expectPush = 1'b1;                       // Hand the expectation over
    expectTest = test;
    expectWord = expected;
    expectLast = last;
    do begin
      @(negedge clock);
      expectPush = 1'b0;
    end while (!busResponse.ack);
    busRequest = '0;
    idleGap();
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int first;
    int last;
    void'($urandom(32'h6085));               // Seeded once
    reset      = 1'b1;
    busRequest = '0;
    expectPush = 1'b0;
    expectTest = '0;
    expectWord = '0;
    expectLast = 1'b0;
    tableReady = 1'b0;
    buildTable();
    tableReady = 1'b1;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    first = 0;
    while (first < stimulus.size()) begin
      last = first;
      while (last + 1 < stimulus.size() && stimulus[last + 1].test == stimulus[first].test
             && last + 1 - first < BURST_LIMIT) begin
        last++;
      end
      for (int i = first; i <= last; i++) busWrite(stimulus[i].command);
      for (int i = first; i <= last; i++) busRead(stimulus[i].test, stimulus[i].expected, i == last);
      first = last + 1;
    end
    repeat (4) @(negedge clock);
    $display("Results checked: %0d of %0d, errors: %0d", checkCount, stimulus.size(), errorCount);
    if (checkCount != stimulus.size()) begin
      $display("Some results were never read back");
    end
    if (errorCount == 0 && checkCount == stimulus.size()) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (tableReady);
    repeat (stimulus.size() * 40) @(posedge clock);
    $display("Timeout: run stopped after %0d cycles without finishing", stimulus.size() * 40);
    $display("Test failed");
    $finish;
  end

endmodule

/* tb/heapChecker.sv */
/*
  Result checker of the heap testbench. Queues the expected word of every read
  that the testbench starts and compares it, in order, with the word returned
  on each read ack. Prints one line per finished test.
*/
module heapChecker (
  input  logic               clock,
  input  logic               reset,
  input  heapPkg::wbRequest  busRequest,
  input  heapPkg::wbResponse busResponse,
  input  logic               expectPush,   // New expectation this cycle
  input  logic [7:0]         expectTest,
  input  logic [31:0]        expectWord,
  input  logic               expectLast,   // Last read of its test
  output int                 checkCount,
  output int                 errorCount
);

  logic [31:0] expectedWords [$];
  logic [7:0]  expectedTests [$];
  logic        expectedLast [$];
  logic        readPending;                 // Read accepted on the previous edge
  int          testChecks;
  int          testErrors;

  task automatic compareResult();
    logic [31:0] expected;
    logic [7:0]  test;
    logic        last;
    if (expectedWords.size() == 0) begin
      $display("ERROR at %0t: a result was read back with no command waiting for it", $time);
      errorCount++;
    end else begin
      expected = expectedWords.pop_front();
      test     = expectedTests.pop_front();
      last     = expectedLast.pop_front();
      checkCount++;
      testChecks++;
      if (busResponse.dat !== expected) begin
        $display("MISMATCH at %0t: busResponse.dat expected %h, actual %h",
                 $time, expected, busResponse.dat);
        errorCount++;
        testErrors++;
      end
      if (last) begin
        $display("Test %0d done: %0d results, %0d mismatches", test, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
      end
    end
  endtask

  // --------------------
  // Bus monitor
  // --------------------
  always @(posedge clock) begin
    if (reset) begin
      checkCount  = 0;
      errorCount  = 0;
      testChecks  = 0;
      testErrors  = 0;
      readPending = 1'b0;
      expectedWords.delete();
      expectedTests.delete();
      expectedLast.delete();
    end else begin
      if (expectPush) begin
        expectedWords.push_back(expectWord);
        expectedTests.push_back(expectTest);
        expectedLast.push_back(expectLast);
      end
      if (busResponse.ack && readPending) compareResult();   // Ack of a heap read
      readPending = busRequest.cyc && busRequest.stb && !busRequest.we && !busRequest.adr;
    end
  end

endmodule
